// File: include/game_consts.svh
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// Matrix geometry, rows and columns alike
`define ROWS 8

// Word FIFO entries, also the sender's starting credits
`define FIFO_DEPTH 4

// Timing in clock_50 cycles
`define SCLK_DIV 2
`define SCROLL_TICKS 1024

// Scroll steps survived for a win
`define WIN_ROWS 16

// Obstacle source, polynomial x^8+x^6+x^5+x^4+1
`define LFSR_SEED 8'hA5
`define LFSR_TAPS 8'hB8

// MAX7219 start-up values
`define INTENSITY 4'hA
`define NORMAL_OP 8'h01
`define DECODE_NONE 8'h00
`define SCAN_ALL 8'h07
`define TEST_OFF 8'h00

// Fixed pictures, row 7 in the top byte
`define PIC_START 64'h0066_4444_2222_6600
`define PIC_VM 64'h0F6F_0F9F_6F0F_0F0F
`define PIC_MV 64'hF0F6_F0F9_F6F0_F0F0
`define PIC_WIN 64'h0024_2400_4224_3C00

`endif

// File: verilog/dodge_pkg.sv
`include "game_consts.svh"

package dodge_pkg;

	// One matrix row, bit 7 is the leftmost dot
	typedef logic [`ROWS-1:0] row_t;

	typedef enum logic [2:0] {
		scr_start,
		scr_play,
		scr_p1_lives,
		scr_p2_lives,
		scr_win
	} screen_t;

	// MAX7219 register addresses
	typedef enum logic [3:0] {
		reg_digit1 = 4'h1,
		reg_digit2 = 4'h2,
		reg_digit3 = 4'h3,
		reg_digit4 = 4'h4,
		reg_digit5 = 4'h5,
		reg_digit6 = 4'h6,
		reg_digit7 = 4'h7,
		reg_digit8 = 4'h8,
		reg_decode_mode = 4'h9,
		reg_intensity = 4'hA,
		reg_scan_limit = 4'hB,
		reg_shutdown = 4'hC,
		reg_display_test = 4'hF
	} max_reg_t;

	typedef struct packed {
		logic [3:0] unused;
		logic [3:0] addr;
		row_t data;
	} max_digit_t;

	typedef struct packed {
		logic [3:0] unused;
		max_reg_t code;
		logic [7:0] value;
	} max_cmd_t;

	// Same 16 bits on the wire, read as a digit row or as a command
	typedef union packed {
		max_digit_t digit;
		max_cmd_t cmd;
	} max_word_t;

endpackage

// File: verilog/dodge_playfield.sv
`timescale 1ns/10ps
`include "game_consts.svh"

module dodge_playfield (
	input  logic clock_50,
	input  logic rst,
	input  logic start,
	input  logic left_1,
	input  logic right_1,
	input  logic left_2,
	input  logic right_2,
	output dodge_pkg::row_t [`ROWS-1:0] rows
);
	import dodge_pkg::*;

	localparam int TICK_W = $clog2(`SCROLL_TICKS);
	localparam int POINT_W = $clog2(`WIN_ROWS);
	localparam row_t P1_HOME = row_t'(1) << 5;
	localparam row_t P2_HOME = row_t'(1) << 2;

	screen_t screen;
	row_t [`ROWS-1:0] obst;
	row_t p1;
	row_t p2;
	row_t p1_nxt;
	row_t p2_nxt;
	row_t fresh;
	logic [7:0] lfsr;
	logic [TICK_W-1:0] tick_cnt;
	logic [POINT_W-1:0] points;
	logic tick;
	logic hit1;
	logic hit2;

	// One step per press, held at the edge
	function automatic row_t step_pos(row_t pos, logic left, logic right);
		if (left && !pos[`ROWS-1])
			return pos << 1;
		if (right && !pos[0])
			return pos >> 1;
		return pos;
	endfunction

	assign p1_nxt = step_pos(p1, left_1, right_1);
	assign p2_nxt = step_pos(p2, left_2, right_2);
	assign tick = (tick_cnt == TICK_W'(`SCROLL_TICKS - 1));

	// Row 1 is the one about to land on the players
	assign hit1 = |(obst[1] & p1_nxt);
	assign hit2 = |(obst[1] & p2_nxt);

	// Never drop a fresh row straight onto a player column
	assign fresh = lfsr & ~(p1_nxt | p2_nxt);

	// ==============================
	// Game state
	always_ff @(posedge clock_50) begin
		if (rst) begin
			screen <= scr_start;
			lfsr <= `LFSR_SEED;
			tick_cnt <= '0;
			points <= '0;
		end else begin
			case (screen)
				scr_start: begin
					if (start) begin
						screen <= scr_play;
						tick_cnt <= '0;
						points <= '0;
					end
				end
				scr_play: begin
					if (tick) begin
						tick_cnt <= '0;
						lfsr <= {lfsr[6:0], ^(lfsr & `LFSR_TAPS)};
						points <= points + 1'b1;
						// Both hit counts as player 1 surviving
						if (hit1 && !hit2)
							screen <= scr_p2_lives;
						else if (hit2)
							screen <= scr_p1_lives;
						else if (points == POINT_W'(`WIN_ROWS - 1))
							screen <= scr_win;
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default: begin
					if (start)
						screen <= scr_start;
				end
			endcase
		end
	end

	// Obstacles and players, loaded when play begins
	always_ff @(posedge clock_50) begin
		if (screen == scr_start && start) begin
			obst <= '0;
			p1 <= P1_HOME;
			p2 <= P2_HOME;
		end else if (screen == scr_play) begin
			p1 <= p1_nxt;
			p2 <= p2_nxt;
			if (tick)
				obst <= {fresh, obst[`ROWS-1:1]};
		end
	end

	// ==============================
	// Picture select
	always_comb begin
		case (screen)
			scr_play: begin
				rows = obst;
				rows[0] = obst[0] | p1 | p2;
			end
			scr_p1_lives: rows = `PIC_MV;
			scr_p2_lives: rows = `PIC_VM;
			scr_win: rows = `PIC_WIN;
			default: rows = `PIC_START;
		endcase
	end

endmodule

// File: verilog/frame_sender.sv
`timescale 1ns/10ps
`include "game_consts.svh"

module frame_sender (
	input  logic clock_50,
	input  logic rst,
	input  dodge_pkg::row_t [`ROWS-1:0] rows,
	input  logic credit_return,
	output logic push,
	output dodge_pkg::max_word_t word
);
	import dodge_pkg::*;

	localparam int CRED_W = $clog2(`FIFO_DEPTH + 1);
	localparam int BOOT_CMDS = 5;

	logic [CRED_W-1:0] credits;
	logic booting;
	logic [2:0] idx;
	logic issue;
	row_t [`ROWS-1:0] snap;
	row_t [`ROWS-1:0] frame;
	row_t col;
	max_reg_t boot_code;
	logic [7:0] boot_value;

	assign issue = (credits != '0);

	// Digit 1 reads the live rows, the rest read the snapshot
	assign frame = (idx == 3'd0) ? rows : snap;

	// Column transpose, row 0 lands in the MSB
	always_comb begin
		for (int r = 0; r < `ROWS; r++)
			col[`ROWS-1-r] = frame[r][`ROWS-1-idx];
	end

	// Start-up command table
	always_comb begin
		case (idx)
			3'd0: begin
				boot_code = reg_shutdown;
				boot_value = `NORMAL_OP;
			end
			3'd1: begin
				boot_code = reg_decode_mode;
				boot_value = `DECODE_NONE;
			end
			3'd2: begin
				boot_code = reg_scan_limit;
				boot_value = `SCAN_ALL;
			end
			3'd3: begin
				boot_code = reg_intensity;
				boot_value = {4'h0, `INTENSITY};
			end
			default: begin
				boot_code = reg_display_test;
				boot_value = `TEST_OFF;
			end
		endcase
	end

	// ==============================
	// Sequencing and credits
	always_ff @(posedge clock_50) begin
		if (rst) begin
			credits <= CRED_W'(`FIFO_DEPTH);
			booting <= 1'b1;
			idx <= '0;
			push <= 1'b0;
		end else begin
			push <= issue;
			if (credit_return && !issue)
				credits <= credits + 1'b1;
			else if (issue && !credit_return)
				credits <= credits - 1'b1;
			if (issue) begin
				if (booting && idx == 3'(BOOT_CMDS - 1)) begin
					booting <= 1'b0;
					idx <= '0;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock_50) begin
		if (issue) begin
			if (booting) begin
				word.cmd.unused <= '0;
				word.cmd.code <= boot_code;
				word.cmd.value <= boot_value;
			end else begin
				word.digit.unused <= '0;
				word.digit.addr <= reg_digit1 + 4'(idx);
				word.digit.data <= col;
				if (idx == 3'd0)
					snap <= rows;
			end
		end
	end

endmodule

// File: verilog/word_fifo.sv
`timescale 1ns/10ps
`include "game_consts.svh"

module word_fifo (
	input  logic clock_50,
	input  logic rst,
	input  logic push,
	input  dodge_pkg::max_word_t word,
	input  logic pop,
	output logic not_empty,
	output dodge_pkg::max_word_t head,
	output logic credit_return
);
	import dodge_pkg::*;

	localparam int PTR_W = $clog2(`FIFO_DEPTH);

	max_word_t mem [`FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;

	assign not_empty = (count != '0);
	assign head = mem[rd_ptr];

	// No full check, the sender's credits guarantee a free slot
	always_ff @(posedge clock_50) begin
		if (push)
			mem[wr_ptr] <= word;
	end

	always_ff @(posedge clock_50) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: verilog/max7219_serializer.sv
`timescale 1ns/10ps
`include "game_consts.svh"

module max7219_serializer (
	input  logic clock_50,
	input  logic rst,
	input  logic not_empty,
	input  dodge_pkg::max_word_t head,
	output logic pop,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);
	localparam int DIV_W = $clog2(`SCLK_DIV);

	logic [15:0] head_bits;
	logic [15:0] shift_reg;
	logic [DIV_W-1:0] div_cnt;
	logic [4:0] bit_cnt;
	logic busy;
	logic div_end;
	logic ready;

	assign head_bits = head;
	assign div_end = (div_cnt == DIV_W'(`SCLK_DIV - 1));

	// Free once the ncs high gap has run its full half period
	assign ready = !busy || (div_end && bit_cnt == 5'd16 && max7219_ncs);
	assign pop = ready && not_empty;

	always_ff @(posedge clock_50) begin
		if (pop)
			shift_reg <= head_bits;
		else if (busy && div_end && max7219_clk)
			shift_reg <= {shift_reg[14:0], 1'b0};
	end

	// ==============================
	// Framing
	always_ff @(posedge clock_50) begin
		if (rst) begin
			busy <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
			max7219_din <= 1'b0;
		end else if (pop) begin
			busy <= 1'b1;
			div_cnt <= '0;
			bit_cnt <= '0;
			max7219_ncs <= 1'b0;
			max7219_clk <= 1'b0;
			max7219_din <= head_bits[15];
		end else if (ready) begin
			busy <= 1'b0;
		end else if (busy) begin
			div_cnt <= div_end ? '0 : div_cnt + 1'b1;
			if (div_end) begin
				if (bit_cnt != 5'd16) begin
					// Data moves only on the falling edge
					max7219_clk <= !max7219_clk;
					if (max7219_clk) begin
						bit_cnt <= bit_cnt + 1'b1;
						max7219_din <= shift_reg[14];
					end
				end else begin
					max7219_ncs <= 1'b1;
					max7219_din <= 1'b0;
				end
			end
		end
	end

endmodule

// File: verilog/dodge_top.sv
`timescale 1ns/10ps
`include "game_consts.svh"

module dodge_top (
	input  logic clock_50,
	input  logic rst,
	input  logic start,
	input  logic left_1,
	input  logic right_1,
	input  logic left_2,
	input  logic right_2,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);
	import dodge_pkg::*;

	row_t [`ROWS-1:0] rows;
	max_word_t word;
	max_word_t head;
	logic push;
	logic pop;
	logic not_empty;
	logic credit_return;

	// ==============================
	// Picture source
	dodge_playfield u_playfield (
		.clock_50 (clock_50),
		.rst      (rst),
		.start    (start),
		.left_1   (left_1),
		.right_1  (right_1),
		.left_2   (left_2),
		.right_2  (right_2),
		.rows     (rows)
	);

	// ==============================
	// Display path
	frame_sender u_sender (
		.clock_50      (clock_50),
		.rst           (rst),
		.rows          (rows),
		.credit_return (credit_return),
		.push          (push),
		.word          (word)
	);

	word_fifo u_fifo (
		.clock_50      (clock_50),
		.rst           (rst),
		.push          (push),
		.word          (word),
		.pop           (pop),
		.not_empty     (not_empty),
		.head          (head),
		.credit_return (credit_return)
	);

	max7219_serializer u_serializer (
		.clock_50    (clock_50),
		.rst         (rst),
		.not_empty   (not_empty),
		.head        (head),
		.pop         (pop),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic clock_50,
	output logic rst
);
	// 4 ns period
	initial begin
		clock_50 = 1'b0;
		forever #2 clock_50 = ~clock_50;
	end

	// Reset held for the first 10 rising edges
	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clock_50);
		#1;
		rst = 1'b0;
	end

endmodule

// File: verif/dodge_tb.sv
`timescale 1ns/10ps
`include "game_consts.svh"

module dodge_tb;
	localparam int TIMEOUT = 40 * `SCROLL_TICKS * `WIN_ROWS;
	localparam int GAP = 1500;

	typedef enum int {ST_START, ST_WAIT_PLAY, ST_PLAY, ST_OVER, ST_BACK} phase_t;

	logic clock_50;
	logic rst;
	logic start;
	logic left_1;
	logic right_1;
	logic left_2;
	logic right_2;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;

	phase_t phase = ST_START;
	int errors = 0;
	int words = 0;
	int frames = 0;
	int cycles = 0;
	int nbits = 0;
	int digit = 0;
	int scrolls = 0;
	// Player model as column index, old is the value before the last press
	int pos1 = 5;
	int pos2 = 2;
	int old1 = 5;
	int old2 = 2;
	logic [15:0] shifter = '0;
	logic [7:0][7:0] frame = '0;
	logic [7:0][7:0] last = '0;
	logic [63:0] result_pic = '0;
	logic [7:0] obst0 = '0;
	logic prev_sclk = 1'b0;
	logic prev_ncs = 1'b1;

	tb_clock clk_gen (
		.clock_50 (clock_50),
		.rst      (rst)
	);

	dodge_top dut (
		.clock_50    (clock_50),
		.rst         (rst),
		.start       (start),
		.left_1      (left_1),
		.right_1     (right_1),
		.left_2      (left_2),
		.right_2     (right_2),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

	// ==============================
	// Reporting
	task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
		errors++;
		$display("mismatch %s got %0h expected %0h", name, got, exp);
	endtask

	task automatic report_failure(string what);
		errors++;
		$display("error: %s", what);
	endtask

	task automatic finish_run();
		$display("errors %0d, words %0d, frames %0d, cycles %0d", errors, words, frames, cycles);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	// MAX7219 start-up sequence, register address then value
	function automatic logic [15:0] boot_word(int n);
		case (n)
			0: return {8'h0C, 8'h01};
			1: return {8'h09, 8'h00};
			2: return {8'h0B, 8'h07};
			3: return {8'h0A, 4'h0, `INTENSITY};
			default: return {8'h0F, 8'h00};
		endcase
	endfunction

	// Candidate k picks old or new position per player
	function automatic logic [7:0] dot1(int k);
		return 8'd1 << ((k % 2 == 1) ? pos1 : old1);
	endfunction

	function automatic logic [7:0] dot2(int k);
		return 8'd1 << ((k / 2 == 1) ? pos2 : old2);
	endfunction

	function automatic logic [63:0] result_for(int k);
		logic h1;
		logic h2;
		h1 = |(last[1] & dot1(k));
		h2 = |(last[1] & dot2(k));
		if (h1 && !h2)
			return `PIC_VM;
		if (h2)
			return `PIC_MV;
		if (scrolls == `WIN_ROWS - 1)
			return `PIC_WIN;
		return '0;
	endfunction

	// ==============================
	// Frame checks
	task automatic check_play();
		logic row0_ok;
		logic row7_ok;
		row0_ok = 1'b0;
		row7_ok = 1'b0;
		if (frame[7:1] != last[7:1]) begin
			scrolls++;
			for (int r = 1; r < 7; r++)
				assert (frame[r] == last[r + 1])
					else report_mismatch($sformatf("row%0d", r), 64'(frame[r]), 64'(last[r + 1]));
			obst0 = last[1];
			for (int k = 0; k < 4; k++)
				if ((frame[7] & (dot1(k) | dot2(k))) == 8'h00)
					row7_ok = 1'b1;
			assert (row7_ok) else report_failure("new row 7 has an obstacle under a player");
		end
		for (int k = 0; k < 4; k++)
			if (frame[0] == (obst0 | dot1(k) | dot2(k)))
				row0_ok = 1'b1;
		assert (row0_ok)
			else report_mismatch("row0", 64'(frame[0]), 64'(obst0 | dot1(3) | dot2(3)));
		assert (scrolls < `WIN_ROWS) else report_failure("play went on past the winning step");
		last = frame;
	endtask

	task automatic check_result();
		logic ok;
		ok = 1'b0;
		for (int k = 0; k < 4; k++)
			if (frame == result_for(k))
				ok = 1'b1;
		assert (ok) else report_mismatch("result", frame, result_for(3));
		result_pic = frame;
		phase = ST_OVER;
	endtask

	task automatic check_frame();
		frames++;
		case (phase)
			ST_START: begin
				assert (frame == `PIC_START) else report_mismatch("frame", frame, `PIC_START);
			end
			ST_WAIT_PLAY: begin
				if (frame != `PIC_START) begin
					phase = ST_PLAY;
					last = '0;
					obst0 = '0;
					scrolls = 0;
					check_play();
				end
			end
			ST_PLAY: begin
				if (frame == `PIC_VM || frame == `PIC_MV || frame == `PIC_WIN)
					check_result();
				else
					check_play();
			end
			ST_OVER: begin
				assert (frame == result_pic) else report_mismatch("frame", frame, result_pic);
			end
			default: begin
				if (frame == `PIC_START) begin
					phase = ST_START;
				end else begin
					assert (frame == result_pic) else report_mismatch("frame", frame, result_pic);
				end
			end
		endcase
	endtask

	task automatic take_word();
		assert (nbits == 16) else report_failure("serial word framed with the wrong bit count");
		if (words < 5) begin
			assert (shifter == boot_word(words))
				else report_mismatch("start-up word", 64'(shifter), 64'(boot_word(words)));
		end else begin
			assert (shifter[15:8] == 8'(digit + 1))
				else report_mismatch("digit address", 64'(shifter[15:8]), 64'(digit + 1));
			// Digit d+1 carries column 7-d, row 0 in the MSB
			for (int r = 0; r < 8; r++)
				frame[r][7 - digit] = shifter[7 - r];
			if (digit == 7) begin
				check_frame();
				digit = 0;
			end else begin
				digit++;
			end
		end
		words++;
	endtask

	// ==============================
	// Serial decoder, sampled mid-cycle
	always @(negedge clock_50) begin
		if (rst) begin
			// Outputs are defined once the first reset edge has been seen
			if (cycles > 0) begin
				assert (max7219_ncs === 1'b1 && max7219_clk === 1'b0 && max7219_din === 1'b0)
					else report_failure("serial lines not idle during reset");
			end
		end else begin
			if (!max7219_ncs && prev_ncs) begin
				shifter = '0;
				nbits = 0;
			end
			if (max7219_clk && !prev_sclk && !max7219_ncs) begin
				shifter = {shifter[14:0], max7219_din};
				nbits++;
			end
			if (max7219_ncs && !prev_ncs)
				take_word();
		end
		prev_sclk = max7219_clk;
		prev_ncs = max7219_ncs;
	end

	always @(posedge clock_50) begin
		cycles++;
		if (cycles == TIMEOUT) begin
			$display("timeout after %0d cycles, the games did not finish", cycles);
			errors++;
			finish_run();
		end
	end

	// ==============================
	// Stimulus
	task automatic pulse(logic l1, logic r1, logic l2, logic r2);
		@(posedge clock_50);
		#1;
		{left_1, right_1, left_2, right_2} = {l1, r1, l2, r2};
		old1 = pos1;
		old2 = pos2;
		if (l1)
			pos1 = (pos1 < 7) ? pos1 + 1 : 7;
		if (r1)
			pos1 = (pos1 > 0) ? pos1 - 1 : 0;
		if (l2)
			pos2 = (pos2 < 7) ? pos2 + 1 : 7;
		if (r2)
			pos2 = (pos2 > 0) ? pos2 - 1 : 0;
		@(posedge clock_50);
		#1;
		{left_1, right_1, left_2, right_2} = 4'b0000;
	endtask

	task automatic press_start();
		@(posedge clock_50);
		#1;
		start = 1'b1;
		@(posedge clock_50);
		#1;
		start = 1'b0;
	endtask

	task automatic idle(int n);
		for (int i = 0; i < n && phase != ST_OVER; i++)
			@(posedge clock_50);
	endtask

	task automatic wait_frames(int n);
		int target;
		target = frames + n;
		while (frames < target)
			@(posedge clock_50);
	endtask

	// Mode 0 walks both players to the edges, 1 stays still, 2 and 3 move one player
	task automatic play_game(int mode);
		int pick;
		pos1 = 5;
		old1 = 5;
		pos2 = 2;
		old2 = 2;
		phase = ST_WAIT_PLAY;
		press_start();
		if (mode == 0) begin
			for (int i = 0; i < 3; i++) begin
				idle(GAP);
				pulse(1'b1, 1'b0, 1'b0, 1'b1);
			end
		end
		while (phase != ST_OVER) begin
			if (mode == 1) begin
				@(posedge clock_50);
			end else begin
				idle(GAP + int'($urandom % GAP));
				pick = int'($urandom % 4);
				if (mode == 2)
					pick = pick % 2;
				if (mode == 3)
					pick = 2 + pick % 2;
				if (phase != ST_OVER)
					pulse(pick == 0, pick == 1, pick == 2, pick == 3);
			end
		end
		wait_frames(3);
		phase = ST_BACK;
		press_start();
		while (phase != ST_START)
			@(posedge clock_50);
		wait_frames(2);
	endtask

	initial begin
		start = 1'b0;
		left_1 = 1'b0;
		right_1 = 1'b0;
		left_2 = 1'b0;
		right_2 = 1'b0;
		void'($urandom(32'hf6c3));
		@(negedge rst);
		wait_frames(2);
		for (int g = 0; g < 5; g++)
			play_game(g);
		finish_run();
	end

endmodule

// File: dodge_top.f
+incdir+include
verilog/dodge_pkg.sv
verilog/dodge_playfield.sv
verilog/frame_sender.sv
verilog/word_fifo.sv
verilog/max7219_serializer.sv
verilog/dodge_top.sv
verif/tb_clock.sv
verif/dodge_tb.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dodge_tb -f dodge_top.f -o dodge_sim

out=$(./obj_dir/dodge_sim)
echo "$out"

if grep -qx "=== PASS ===" <<< "$out"; then
	exit 0
fi
exit 1
